// File: design/accel_pkg.sv
// accel capture package
// command codes, transaction lengths, divider and buffer sizes
package accel_pkg;

  // spi command bytes sent first in every transaction
  localparam logic [7:0] CMD_READ_ID  = 8'h01; // device id read
  localparam logic [7:0] CMD_READ_XYZ = 8'h11; // xyz data read

  localparam int LEN_W = 4; // length field width
  localparam int SEQ_W = LEN_W + 4; // sequence index, 16 ticks per byte

  // lengths count the command byte too
  localparam logic [LEN_W-1:0] LEN_READ_ID  = 4'd5;
  localparam logic [LEN_W-1:0] LEN_READ_XYZ = 4'd10;

  localparam int CLK_DIV      = 4;   // system clocks per tick
  localparam int SAMPLE_TICKS = 200; // sample period above the 16*10+4 tick read
  localparam int DIV_W        = $clog2(CLK_DIV);
  localparam int TICK_W       = $clog2(SAMPLE_TICKS);

  localparam int BUF_AW    = 6;
  localparam int BUF_DEPTH = 2 ** BUF_AW; // 64 bytes
  localparam int WR_CNT_W  = 16;        // saturating write counter

  typedef logic [7:0]        byte_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [BUF_AW-1:0] buf_addr_t;

endpackage

// File: design/read_req_if.sv
// read request bundle from the sample scheduler to the spi reader
// tick enable, start strobe, command byte and transaction length
`timescale 1ns/100ps

interface read_req_if;
  import accel_pkg::*;

  logic  tick;  // one clock every CLK_DIV clocks
  logic  start; // one clock, lands on a tick
  byte_t cmd;   // held from start to next start
  len_t  len;   // bytes incl. command byte

  modport scheduler (
    output tick, start, cmd, len
  );

  modport reader (
    input tick, start, cmd, len
  );

endinterface

// File: design/sample_scheduler.sv
// sample scheduler
// divides clk into the reader tick and issues a periodic read request
`timescale 1ns/100ps

module sample_scheduler
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           run,      // host enables periodic sampling
  input  logic           read_xyz, // 0 reads the id, 1 reads xyz data
  read_req_if.scheduler  req
);
  import accel_pkg::*;

  logic [DIV_W-1:0]  div_cnt;
  logic [TICK_W-1:0] tick_cnt;
  logic              div_wrap; // next clock carries a tick
  logic              period_end; // last tick of the sample period

  assign div_wrap   = (div_cnt == DIV_W'(CLK_DIV - 1));
  assign period_end = (tick_cnt == TICK_W'(SAMPLE_TICKS - 1));

  // clock enable divider, free running
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt  <= '0;
      req.tick <= 1'b0;
    end
    else
    begin
      div_cnt  <= div_wrap ? '0 : div_cnt + 1'b1;
      req.tick <= div_wrap;
    end
  end

  // sample period counter, held at zero while stopped
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tick_cnt  <= '0;
      req.start <= 1'b0;
      req.cmd   <= CMD_READ_ID;
      req.len   <= LEN_READ_ID;
    end
    else
    begin
      req.start <= run && div_wrap && period_end; // same clock as the tick
      if (!run)
        tick_cnt <= '0;
      else if (div_wrap)
        tick_cnt <= period_end ? '0 : tick_cnt + 1'b1;
      if (run && div_wrap && period_end)
      begin
        // command and length go out together with start
        req.cmd <= read_xyz ? CMD_READ_XYZ : CMD_READ_ID;
        req.len <= read_xyz ? LEN_READ_XYZ : LEN_READ_ID;
      end
    end
  end

endmodule

// File: design/accel_spi_reader.sv
// spi reader for the accelerometer
// runs one tick-sequenced read per start and strobes out each data byte,
// direct mode hands the sensor pins to the host while idle
`timescale 1ns/100ps

module accel_spi_reader
(
  input  logic             clk,
  input  logic             rst_n,
  read_req_if.reader       req,
  input  logic             direct,      // 0 buffering, 1 host drives the sensor
  input  logic             direct_mosi,
  input  logic             direct_sclk,
  input  logic             direct_csn,
  output logic             adxl_mosi,
  output logic             adxl_sclk,
  output logic             adxl_csn,
  input  logic             adxl_miso,
  output accel_pkg::byte_t wrdata,      // valid with wr
  output logic             wr,          // one clock per data byte
  output logic             first        // first data byte of a transaction
);
  import accel_pkg::*;

  byte_t            cmd_r;       // command of the running transaction
  len_t             len_r;       // its length incl. command
  logic [SEQ_W-1:0] seq_idx;     // tick index inside the transaction
  logic [SEQ_W-2:0] bit_slot;    // sclk period number
  logic             idle;
  logic             accept;      // start taken this clock
  logic             shift_en;    // even tick while busy
  logic             mode_direct;
  logic             csn_r;
  logic             sclk_en;
  logic             sclk_r;
  byte_t            mosi_sr;
  byte_t            miso_sr;
  byte_t            byte_mark;   // one hot, bit 7 marks a full byte

  assign idle     = (seq_idx == {len_r, 4'h4}); // parked at end of sequence
  assign accept   = req.start && idle && !mode_direct;
  assign bit_slot = seq_idx[SEQ_W-1:1];
  assign shift_en = req.tick && !seq_idx[0] && !idle;

  // sequence index, restarts on an accepted start
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      seq_idx <= {LEN_READ_ID, 4'h4}; // idle
      len_r   <= LEN_READ_ID;
      cmd_r   <= CMD_READ_ID;
    end
    else if (accept)
    begin
      seq_idx <= '0;
      cmd_r   <= req.cmd;
      len_r   <= req.len;
    end
    else if (req.tick && !idle)
      seq_idx <= seq_idx + 1'b1;
  end

  // chip select, sclk gating and mode switch
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      csn_r       <= 1'b1;
      sclk_en     <= 1'b0;
      sclk_r      <= 1'b0;
      mode_direct <= 1'b0;
    end
    else if (req.tick)
    begin
      if (seq_idx == '0)
        csn_r <= 1'b0; // one tick after start
      else if (seq_idx == {len_r, 4'h3})
        csn_r <= 1'b1; // after the last bit
      if (seq_idx == SEQ_W'(2))
        sclk_en <= 1'b1;
      else if (seq_idx == {len_r, 4'h2})
        sclk_en <= 1'b0;
      sclk_r <= sclk_en ? seq_idx[0] : 1'b0; // high on odd ticks
      // never flip in the clock that accepts a start
      if (idle && !accept)
        mode_direct <= direct;
    end
  end

  // mosi shifter and write strobes
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mosi_sr <= '0;
      wr      <= 1'b0;
      first   <= 1'b0;
    end
    else
    begin
      wr    <= 1'b0;
      first <= 1'b0;
      if (shift_en)
      begin
        mosi_sr <= (bit_slot == 1) ? cmd_r : {mosi_sr[6:0], 1'b0};
        wr      <= byte_mark[7] && (bit_slot != 9) && sclk_en;  // skip command echo
        first   <= byte_mark[7] && (bit_slot == 17) && sclk_en; // byte after the command
      end
    end
  end

  // miso assembly, sampled while sclk is high
  always_ff @(posedge clk)
  begin
    if (shift_en)
    begin
      miso_sr   <= {miso_sr[6:0], adxl_miso};
      byte_mark <= (bit_slot == 1) ? 8'h01 : {byte_mark[6:0], byte_mark[7]};
      if (byte_mark[7])
        wrdata <= {miso_sr[6:0], adxl_miso}; // complete byte incl. current bit
    end
  end

  // pin multiplexer
  assign adxl_csn  = mode_direct ? direct_csn  : csn_r;
  assign adxl_sclk = mode_direct ? direct_sclk : sclk_r;
  assign adxl_mosi = mode_direct ? direct_mosi : mosi_sr[7];

endmodule

// File: design/sample_buffer.sv
// sample ring buffer
// stores received bytes with a wrapping write pointer, host reads by address
`timescale 1ns/100ps

module sample_buffer
(
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            wr,
  input  accel_pkg::byte_t                wrdata,
  input  logic                            first,      // marks a frame start
  input  accel_pkg::buf_addr_t            rd_addr,
  output accel_pkg::byte_t                rd_data,    // one clock after rd_addr
  output accel_pkg::buf_addr_t            frame_addr, // latest frame start
  output logic [accel_pkg::WR_CNT_W-1:0]  wr_count    // total bytes, saturating
);
  import accel_pkg::*;

  byte_t     mem [0:BUF_DEPTH-1];
  buf_addr_t wr_ptr; // wraps at BUF_DEPTH

  // write port
  always_ff @(posedge clk)
  begin
    if (wr)
      mem[wr_ptr] <= wrdata;
  end

  // read port, registered
  always_ff @(posedge clk)
  begin
    rd_data <= mem[rd_addr];
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr     <= '0;
      frame_addr <= '0;
      wr_count   <= '0;
    end
    else if (wr)
    begin
      wr_ptr <= wr_ptr + 1'b1; // overwrites oldest once wrapped
      if (first)
        frame_addr <= wr_ptr;
      if (wr_count != '1)
        wr_count <= wr_count + 1'b1;
    end
  end

endmodule

// File: design/accel_capture_top.sv
// accelerometer capture top
// scheduler, spi reader and ring buffer behind plain host and sensor pins
`timescale 1ns/100ps

module accel_capture_top
(
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            run,
  input  logic                            read_xyz,
  input  logic                            direct,
  input  logic                            direct_mosi,
  input  logic                            direct_sclk,
  input  logic                            direct_csn,
  output logic                            adxl_mosi,
  output logic                            adxl_sclk,
  output logic                            adxl_csn,
  input  logic                            adxl_miso,
  input  accel_pkg::buf_addr_t            rd_addr,
  output accel_pkg::byte_t                rd_data,
  output accel_pkg::buf_addr_t            frame_addr,
  output logic [accel_pkg::WR_CNT_W-1:0]  wr_count
);

  accel_pkg::byte_t wrdata; // reader to buffer
  logic             wr;
  logic             first;

  read_req_if u_req ();

  sample_scheduler u_sched (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (run),
    .read_xyz (read_xyz),
    .req      (u_req.scheduler)
  );

  accel_spi_reader u_reader (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (u_req.reader),
    .direct      (direct),
    .direct_mosi (direct_mosi),
    .direct_sclk (direct_sclk),
    .direct_csn  (direct_csn),
    .adxl_mosi   (adxl_mosi),
    .adxl_sclk   (adxl_sclk),
    .adxl_csn    (adxl_csn),
    .adxl_miso   (adxl_miso),
    .wrdata      (wrdata),
    .wr          (wr),
    .first       (first)
  );

  sample_buffer u_buf (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr         (wr),
    .wrdata     (wrdata),
    .first      (first),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .frame_addr (frame_addr),
    .wr_count   (wr_count)
  );

endmodule

// File: testbench/spi_sensor_model.sv
// spi sensor model, mode 0 slave
// records the command byte of each csn window and serves queued response bytes
`timescale 1ns/100ps

module spi_sensor_model
(
  input  logic             adxl_mosi,
  input  logic             adxl_sclk,
  input  logic             adxl_csn,
  output logic             adxl_miso,
  output accel_pkg::byte_t win_cmd,     // command of the last closed window
  output int               win_periods, // sclk periods in that window
  output int               win_count    // closed csn-low windows
);
  import accel_pkg::*;

  byte_t rsp_q [$];  // response bytes in serving order
  byte_t rx_sr;
  byte_t tx_sr;
  byte_t cmd_r;
  int    bit_cnt;
  logic  in_window;
  logic  pending;    // popped byte with no bit clocked out yet

  task automatic push_response(input byte_t b);
    rsp_q.push_back(b);
  endtask

  task automatic clear_responses();
    rsp_q.delete();
  endtask

  initial
  begin
    adxl_miso   = 1'b0;
    win_cmd     = '0;
    win_periods = 0;
    win_count   = 0;
    bit_cnt     = 0;
    in_window   = 1'b0;
    pending     = 1'b0;
  end

  always @(negedge adxl_csn)
  begin
    in_window = (adxl_csn === 1'b0);
    bit_cnt   = 0;
    tx_sr     = 8'h00; // nothing useful during the command byte
    pending   = 1'b0;
    adxl_miso = 1'b0;
  end

  // mosi sampled on the rising edge
  always @(posedge adxl_sclk)
  begin
    if (in_window && !adxl_csn)
    begin
      rx_sr   = {rx_sr[6:0], adxl_mosi};
      bit_cnt = bit_cnt + 1;
      pending = 1'b0;
      if (bit_cnt == 8)
        cmd_r = rx_sr;
    end
  end

  // miso changes on the falling edge
  always @(negedge adxl_sclk)
  begin
    if (in_window && !adxl_csn)
    begin
      if (bit_cnt % 8 == 0)
      begin
        tx_sr   = 8'h00;
        if (rsp_q.size() > 0)
          tx_sr = rsp_q.pop_front();
        pending = 1'b1;
      end
      else
        tx_sr = {tx_sr[6:0], 1'b0};
      adxl_miso = tx_sr[7];
    end
  end

  always @(posedge adxl_csn)
  begin
    if (in_window)
    begin
      if (pending)
        rsp_q.push_front(tx_sr); // last falling edge fetched one byte too many
      pending     = 1'b0;
      in_window   = 1'b0;
      win_cmd     = cmd_r;
      win_periods = bit_cnt;
      win_count   = win_count + 1;
    end
  end

endmodule

// File: testbench/accel_checker.sv
// capture checker
// compares buffer readback, per-window spi results and direct pin routing
`timescale 1ns/100ps

module accel_checker
(
  input  logic                           clk,
  input  accel_pkg::buf_addr_t           rd_addr,
  input  accel_pkg::byte_t               rd_data,
  input  accel_pkg::buf_addr_t           frame_addr,
  input  logic [accel_pkg::WR_CNT_W-1:0] wr_count,
  input  logic                           direct_mosi,
  input  logic                           direct_sclk,
  input  logic                           direct_csn,
  input  logic                           adxl_mosi,
  input  logic                           adxl_sclk,
  input  logic                           adxl_csn,
  input  accel_pkg::byte_t               win_cmd,
  input  int                             win_periods,
  input  int                             win_count,
  input  logic                           cmp_en,    // rd_addr is a checked read
  input  accel_pkg::byte_t               cmp_exp,
  input  logic                           follow_en, // sensor pins must follow host pins
  input  accel_pkg::byte_t               exp_cmd,
  input  int                             exp_count,
  input  int                             exp_frame,
  input  logic                           test_end,
  output int                             checks,
  output int                             errors,
  output int                             tests
);
  import accel_pkg::*;

  logic      cmp_q;   // read issued last clock
  byte_t     exp_q;
  buf_addr_t addr_q;
  int        last_win;
  int        test_checks;
  int        test_errs;

  initial
  begin
    cmp_q       = 1'b0;
    exp_q       = '0;
    addr_q      = '0;
    last_win    = 0;
    test_checks = 0;
    test_errs   = 0;
    checks      = 0;
    errors      = 0;
    tests       = 0;
  end

  // sclk periods per window, 8 per byte incl. the command byte
  function automatic int periods_for(input byte_t cmd);
    if (cmd == 8'h11)
      return 80;
    else if (cmd == 8'h01)
      return 40;
    return 0;
  endfunction

  task automatic expect_eq(input string what, input int got, input int exp);
    checks++;
    test_checks++;
    if (got != exp)
    begin
      errors++;
      test_errs++;
      $display("Fail at %0t: %s got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  always @(posedge clk)
  begin
    if (cmp_q)
      expect_eq($sformatf("rd_data at address %0d", addr_q), rd_data, exp_q);
    cmp_q  <= cmp_en; // rd_data lands one clock after rd_addr
    exp_q  <= cmp_exp;
    addr_q <= rd_addr;
    if (follow_en)
    begin
      expect_eq("adxl_mosi in direct mode", adxl_mosi, direct_mosi);
      expect_eq("adxl_sclk in direct mode", adxl_sclk, direct_sclk);
      expect_eq("adxl_csn in direct mode", adxl_csn, direct_csn);
      expect_eq("wr_count in direct mode", wr_count, exp_count); // no writes
    end
    if (win_count != last_win)
    begin
      last_win = win_count;
      if (!follow_en) // host windows carry no capture
      begin
        expect_eq("command byte", win_cmd, exp_cmd);
        expect_eq("sclk periods", win_periods, periods_for(exp_cmd));
        expect_eq("wr_count after window", wr_count, exp_count);
        expect_eq("frame_addr after window", frame_addr, exp_frame);
      end
    end
    if (test_end)
    begin
      tests++;
      $display("test %0d done at %0t: %0d checks, %0d errors",
               tests, $time, test_checks, test_errs);
      test_checks = 0;
      test_errs   = 0;
    end
  end

endmodule

// File: testbench/accel_assertions.sv
// spi pin protocol and write strobe assertions, bound onto the spi reader
`timescale 1ns/100ps

module accel_assertions
(
  input logic clk,
  input logic rst_n,
  input logic adxl_csn,
  input logic adxl_sclk,
  input logic wr,
  input logic first
);

  int unsigned assert_fails = 0; // tally for the end of run summary

  // chip select only falls with sclk low
  csn_fall_sclk_low: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(adxl_csn) |-> !adxl_sclk && !$past(adxl_sclk))
    else
    begin
      $error("adxl_csn fell while adxl_sclk was high");
      assert_fails++;
    end

  wr_one_clock: assert property (@(posedge clk) disable iff (!rst_n) wr |=> !wr)
    else
    begin
      $error("wr stayed high for more than one clock");
      assert_fails++;
    end

  first_with_wr: assert property (@(posedge clk) disable iff (!rst_n) first |-> wr)
    else
    begin
      $error("first was high without wr");
      assert_fails++;
    end

endmodule

bind accel_spi_reader accel_assertions u_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .adxl_csn  (adxl_csn),
  .adxl_sclk (adxl_sclk),
  .wr        (wr),
  .first     (first)
);

// File: testbench/tb_accel_capture.sv
// testbench for the accelerometer capture top
// runs each testdata test after a reset and reads the ring buffer back
`timescale 1ns/100ps

module tb_accel_capture;
  import accel_pkg::*;

  logic                clk;
  logic                rst_n;
  logic                run;
  logic                read_xyz;
  logic                direct;
  logic                direct_mosi;
  logic                direct_sclk;
  logic                direct_csn;
  logic                adxl_mosi;
  logic                adxl_sclk;
  logic                adxl_csn;
  logic                adxl_miso;
  buf_addr_t           rd_addr;
  byte_t               rd_data;
  buf_addr_t           frame_addr;
  logic [WR_CNT_W-1:0] wr_count;

  byte_t win_cmd;
  int    win_periods;
  int    win_count;
  logic  cmp_en;
  byte_t cmp_exp;
  logic  follow_en;
  byte_t exp_cmd;
  int    exp_count;   // bytes written up to the current transaction
  int    exp_frame;   // start address of the current transaction
  logic  test_end;
  int    checks;
  int    errors;
  int    tests;

  byte_t td [0:255];             // testdata words
  byte_t image [0:BUF_DEPTH-1];  // expected buffer contents
  int    cycles;
  int    limit;

  accel_capture_top u_dut (.*);

  spi_sensor_model u_sensor (
    .adxl_mosi   (adxl_mosi),
    .adxl_sclk   (adxl_sclk),
    .adxl_csn    (adxl_csn),
    .adxl_miso   (adxl_miso),
    .win_cmd     (win_cmd),
    .win_periods (win_periods),
    .win_count   (win_count)
  );

  accel_checker u_chk (
    .clk         (clk),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .frame_addr  (frame_addr),
    .wr_count    (wr_count),
    .direct_mosi (direct_mosi),
    .direct_sclk (direct_sclk),
    .direct_csn  (direct_csn),
    .adxl_mosi   (adxl_mosi),
    .adxl_sclk   (adxl_sclk),
    .adxl_csn    (adxl_csn),
    .win_cmd     (win_cmd),
    .win_periods (win_periods),
    .win_count   (win_count),
    .cmp_en      (cmp_en),
    .cmp_exp     (cmp_exp),
    .follow_en   (follow_en),
    .exp_cmd     (exp_cmd),
    .exp_count   (exp_count),
    .exp_frame   (exp_frame),
    .test_end    (test_end),
    .checks      (checks),
    .errors      (errors),
    .tests       (tests)
  );

  always #5 clk = ~clk; // 10 ns period

  // watchdog
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= limit)
    begin
      $display("timeout: run did not finish within %0d clocks", limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // bytes per transaction incl. the command byte
  function automatic int txn_len(input byte_t cmd);
    return (cmd == 8'h11) ? 10 : 5;
  endfunction

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // host owns the pins for two sample periods, captures must stay off
  task automatic direct_phase();
    int i;
    @(negedge clk);
    direct = 1'b1;
    run    = 1'b1;
    repeat (2 * CLK_DIV) @(negedge clk); // mode register follows at a tick
    follow_en = 1'b1;
    for (i = 0; i < 2 * SAMPLE_TICKS * CLK_DIV; i++)
    begin
      @(negedge clk);
      direct_mosi = i[0];
      direct_csn  = i[3];                // empty csn windows for the sensor
      direct_sclk = i[3] & i[1] & ~i[2]; // pulses only while csn is high
    end
    @(negedge clk);
    follow_en   = 1'b0;
    direct_mosi = 1'b0;
    direct_sclk = 1'b0;
    direct_csn  = 1'b1;
    direct      = 1'b0;
  endtask

  task automatic read_back(input int total);
    int a;
    int n;
    n = (total < BUF_DEPTH) ? total : BUF_DEPTH;
    for (a = 0; a < n; a++)
    begin
      @(negedge clk);
      rd_addr = buf_addr_t'(a);
      cmp_en  = 1'b1;
      cmp_exp = image[a];
    end
    @(negedge clk);
    cmp_en = 1'b0;
    repeat (2) @(negedge clk);
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  task automatic run_test(inout int p);
    byte_t mode;
    int    ntr;
    int    tr_pos [0:15];
    int    total;
    int    k;
    int    j;
    mode = td[p];
    ntr  = td[p+1];
    p    = p + 2;
    for (k = 0; k < ntr; k++)
    begin
      tr_pos[k] = p;
      p = p + txn_len(td[p]);
    end
    apply_reset();
    u_sensor.clear_responses();
    total = 0;
    for (k = 0; k < ntr; k++)
      for (j = 1; j < txn_len(td[tr_pos[k]]); j++)
      begin
        u_sensor.push_response(td[tr_pos[k] + j]);
        image[total % BUF_DEPTH] = td[tr_pos[k] + j]; // newer bytes win after a wrap
        total++;
      end
    read_xyz  = (td[tr_pos[0]] == 8'h11);
    exp_cmd   = td[tr_pos[0]];
    exp_frame = 0;
    exp_count = 0;
    if (mode == 8'h0d)
      direct_phase();
    exp_count = txn_len(exp_cmd) - 1;
    run = 1'b1;
    for (k = 0; k < ntr; k++)
    begin
      @(negedge adxl_csn); // transaction k under way
      if (k + 1 < ntr)
      begin
        @(negedge clk);
        read_xyz = (td[tr_pos[k+1]] == 8'h11); // only the next start sees it
      end
      @(posedge adxl_csn);
      repeat (2) @(negedge clk); // checker has seen the closed window
      if (k + 1 < ntr)
      begin
        exp_frame = exp_count % BUF_DEPTH;
        exp_cmd   = td[tr_pos[k+1]];
        exp_count = exp_count + txn_len(exp_cmd) - 1;
      end
    end
    @(negedge clk);
    run = 1'b0;
    read_back(total);
  endtask

  initial
  begin
    int p;
    int ntr;
    int n_tr;
    int n_tests;
    int n_direct;
    clk         = 1'b0;
    rst_n       = 1'b0;
    run         = 1'b0;
    read_xyz    = 1'b0;
    direct      = 1'b0;
    direct_mosi = 1'b0;
    direct_sclk = 1'b0;
    direct_csn  = 1'b1;
    rd_addr     = '0;
    cmp_en      = 1'b0;
    cmp_exp     = '0;
    follow_en   = 1'b0;
    exp_cmd     = '0;
    exp_count   = 0;
    exp_frame   = 0;
    test_end    = 1'b0;
    cycles      = 0;
    limit       = 1000000;
    $readmemh("testbench/accel_testdata.txt", td);
    if ($isunknown(td[0]))
    begin
      $display("testdata file is missing or empty");
      $display("SIMULATION FAILED");
    end
    else
    begin
      // size the timeout from the number of transactions
      p        = 0;
      n_tr     = 0;
      n_tests  = 0;
      n_direct = 0;
      while (td[p] !== 8'hff && p < 250)
      begin
        n_tests++;
        if (td[p] == 8'h0d)
          n_direct++;
        ntr  = td[p+1];
        n_tr = n_tr + ntr;
        p    = p + 2;
        repeat (ntr)
          p = p + txn_len(td[p]);
      end
      limit = (n_tr + 2 * n_direct) * (SAMPLE_TICKS + 200) * CLK_DIV
              + 200 * n_tests + 1000;
      p = 0;
      while (td[p] !== 8'hff && p < 250)
        run_test(p);
      repeat (4) @(negedge clk);
      $display("totals: %0d tests, %0d checks, %0d errors, %0d assertion failures",
               tests, checks, errors, u_dut.u_reader.u_assert.assert_fails);
      if (errors == 0 && u_dut.u_reader.u_assert.assert_fails == 0)
        $display("SIMULATION PASSED");
      else
        $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
design/accel_pkg.sv
design/read_req_if.sv
design/sample_scheduler.sv
design/accel_spi_reader.sv
design/sample_buffer.sv
design/accel_capture_top.sv
testbench/spi_sensor_model.sv
testbench/accel_checker.sv
testbench/accel_assertions.sv
testbench/tb_accel_capture.sv

// File: testbench/accel_testdata.txt
// mode (00 buffering, 0d direct phase first), transaction count,
// then per transaction its command byte and the sensor response bytes; ff ends
// id read, two transactions
00 02
01 e5 ed 1d 11
01 a0 a1 a2 a3
// xyz read, three transactions
00 03
11 10 11 12 13 14 15 16 17 18
11 20 21 22 23 24 25 26 27 28
11 30 31 32 33 34 35 36 37 38
// read_xyz switched mid-run, id then xyz then id
00 03
01 41 42 43 44
11 50 51 52 53 54 55 56 57 58
01 45 46 47 48
// direct mode, then one id capture
0d 01
01 5a a5 3c c3
// wrap, eight xyz transactions give 72 bytes
00 08
11 80 81 82 83 84 85 86 87 88
11 89 8a 8b 8c 8d 8e 8f 90 91
11 92 93 94 95 96 97 98 99 9a
11 9b 9c 9d 9e 9f a0 a1 a2 a3
11 a4 a5 a6 a7 a8 a9 aa ab ac
11 ad ae af b0 b1 b2 b3 b4 b5
11 b6 b7 b8 b9 ba bb bc bd be
11 bf c0 c1 c2 c3 c4 c5 c6 c7
ff
